// File: files.f
+incdir+rtl
rtl/ipu_pkg.sv
rtl/ipu_operand_decode.sv
rtl/ipu_simd_lane.sv
rtl/ipu_result_collect.sv
rtl/spatz_ipu.sv
testbench/ipu_checker.sv
testbench/tb_spatz_ipu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f files.f --top-module tb_spatz_ipu -o sim_tb_spatz_ipu

output=$(./obj_dir/sim_tb_spatz_ipu)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

// File: testbench/ipu_tests.txt
// name opcode sew s1 s2 tag expected, all but the name in hex
// opcode 0 add 1 sub 2 and 3 or 4 xor 5 min 6 max 7 minu 8 maxu, sew 0 8b 1 16b 2 32b
add8_wrap   0 0 FF80017F 01800101 1 00000280
sub8_wrap   1 0 00010280 01020301 2 FFFFFF7F
add16_wrap  0 1 FFFF8000 00018000 3 00000000
sub16_wrap  1 1 00000001 00010002 4 FFFFFFFF
add32_wrap  0 2 FFFFFFFF 00000002 5 00000001
sub32_wrap  1 2 00000000 00000001 6 FFFFFFFF
min8_s      5 0 80FF7F01 7F0180FF 7 80FF80FF
max8_s      6 0 80FF7F01 7F0180FF 8 7F017F01
minu8       7 0 80FF7F01 7F0180FF 9 7F017F01
maxu8       8 0 80FF7F01 7F0180FF A 80FF80FF
min16_s     5 1 8000FFFF 7FFF0001 B 8000FFFF
max16_s     6 1 8000FFFF 7FFF0001 C 7FFF0001
minu16      7 1 8000FFFF 7FFF0001 D 7FFF0001
maxu16      8 1 8000FFFF 7FFF0001 E 8000FFFF
min32_s     5 2 80000000 7FFFFFFF F 80000000
max32_s     6 2 80000000 7FFFFFFF 0 7FFFFFFF
minu32      7 2 80000000 7FFFFFFF 1 7FFFFFFF
maxu32      8 2 80000000 7FFFFFFF 2 80000000
and32       2 2 F0F0AAAA 0FF0FF00 3 00F0AA00
or32        3 2 F0F0AAAA 0FF0FF00 4 FFF0FFAA
xor32       4 2 F0F0AAAA 0FF0FF00 5 FF0055AA
and8        2 0 8F0F55FF 81F0AA0F 6 8100000F
or8         3 0 8F0F55FF 81F0AA0F 7 8FFFFFFF
xor8        4 0 8F0F55FF 81F0AA0F 8 0EFFFFF0
min8_s_up   5 0 FEFD1234 FF801235 9 FE801234
maxu8_up    8 0 FEFD1234 FF801235 A FFFD1235
add8_mix    0 0 12345678 F0E0D0C0 B 02142638
sub16_mix   1 1 12345678 56781234 C BBBC4444
max16_s_neg 6 1 FFFE8001 FFFF8000 D FFFF8001
xor8_mix    4 0 A5A5A5A5 5A5A0000 E FFFFA5A5

// File: testbench/tb_spatz_ipu.sv
////////////////////////////////////////////////////////////////////////////
// IPU testbench
// File driven stimulus, randomly delayed credit return and timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ipu_params.svh"

module tb_spatz_ipu import ipu_pkg::*; ();

    localparam int MAX_VEC = 64;

    logic     clk_i;
    logic     rst_i;
    logic     op_valid_i;
    op_e      op_i;
    sew_e     sew_i;
    elen_t    op_s1_i;
    elen_t    op_s2_i;
    ipu_tag_t tag_i;
    logic     result_credit_i;
    logic     op_ready_o;
    logic     result_valid_o;
    elen_t    result_o;
    ipu_tag_t tag_o;

    logic [191:0] cur_name;
    elen_t        cur_exp;
    int           errors;
    int           results;

    // Test vectors
    logic [191:0] v_name [MAX_VEC];
    logic [3:0]   v_op   [MAX_VEC];
    logic [1:0]   v_sew  [MAX_VEC];
    elen_t        v_s1   [MAX_VEC];
    elen_t        v_s2   [MAX_VEC];
    ipu_tag_t     v_tag  [MAX_VEC];
    elen_t        v_exp  [MAX_VEC];
    int           n_vec;
    int           limit;
    int           cycles;
    logic         took;
    logic [31:0]  lfsr;
    int           due_q[$];

    spatz_ipu spatz_ipu_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .op_s1_i        (op_s1_i),
        .op_s2_i        (op_s2_i),
        .tag_i          (tag_i),
        .result_credit_i(result_credit_i),
        .op_ready_o     (op_ready_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .tag_o          (tag_o)
    );

    ipu_checker i_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_valid_i     (op_valid_i),
        .op_ready_i     (op_ready_o),
        .op_tag_i       (tag_i),
        .exp_i          (cur_exp),
        .name_i         (cur_name),
        .result_credit_i(result_credit_i),
        .result_valid_i (result_valid_o),
        .result_i       (result_o),
        .tag_i          (tag_o),
        .errors_o       (errors),
        .results_o      (results)
    );

    always #2 clk_i = ~clk_i;

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic load_vectors();
        int           fd;
        int           r;
        string        line;
        logic [191:0] name;
        logic [31:0]  op, sew, s1, s2, tag, exp;
        fd    = $fopen("testbench/ipu_tests.txt", "r");
        n_vec = 0;
        if (fd == 0) begin
            $display("Could not open the test vector file");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                r = $fgets(line, fd);
                if (r != 0) begin
                    r = $sscanf(line, "%s %h %h %h %h %h %h", name, op, sew, s1, s2, tag, exp);
                    if (r == 7) begin
                        v_name[n_vec] = name;
                        v_op[n_vec]   = op[3:0];
                        v_sew[n_vec]  = sew[1:0];
                        v_s1[n_vec]   = s1;
                        v_s2[n_vec]   = s2;
                        v_tag[n_vec]  = tag[3:0];
                        v_exp[n_vec]  = exp;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    always @(posedge clk_i) begin
        took   <= op_valid_i && op_ready_o;
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout, the run went past %0d cycles", limit);
            $display("errors %0d, results %0d of %0d", errors + 1, results, n_vec);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int   idx;
        int   stall;
        logic withhold;
        logic [1:0] delay;
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        op_valid_i      = 1'b0;
        op_i            = VADD;
        sew_i           = EW_32;
        op_s1_i         = '0;
        op_s2_i         = '0;
        tag_i           = '0;
        result_credit_i = 1'b0;
        cur_name        = '0;
        cur_exp         = '0;
        cycles          = 0;
        took            = 1'b0;
        lfsr            = 32'd73788;
        limit           = 100000;
        load_vectors();
        limit    = 10 * n_vec + 100;
        idx      = 0;
        stall    = 0;
        withhold = 1'b1;

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        while (!(idx == n_vec && results == n_vec && due_q.size() == 0)) begin
            @(negedge clk_i);
            if (took) begin
                idx++;
            end
            // Hold credits back until the unit has stalled for a while
            if (withhold && !op_ready_o) begin
                stall++;
                if (stall >= 4) begin
                    withhold = 1'b0;
                end
            end
            if (result_valid_o) begin
                delay[0] = lfsr[0];
                lfsr     = lfsr_next(lfsr);
                delay[1] = lfsr[0];
                lfsr     = lfsr_next(lfsr);
                due_q.push_back(cycles + int'(delay));
            end
            result_credit_i = 1'b0;
            if (!withhold) begin
                for (int i = 0; i < due_q.size(); i++) begin
                    if (!result_credit_i && due_q[i] <= cycles) begin
                        due_q.delete(i);
                        result_credit_i = 1'b1;
                    end
                end
            end
            if (idx < n_vec) begin
                op_valid_i = 1'b1;
                op_i       = op_e'(v_op[idx]);
                sew_i      = sew_e'(v_sew[idx]);
                op_s1_i    = v_s1[idx];
                op_s2_i    = v_s2[idx];
                tag_i      = v_tag[idx];
                cur_name   = v_name[idx];
                cur_exp    = v_exp[idx];
            end else begin
                op_valid_i = 1'b0;
            end
        end

        repeat (4) @(negedge clk_i);
        $display("errors %0d, results %0d of %0d", errors, results, n_vec);
        if (errors == 0 && n_vec > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/ipu_checker.sv
////////////////////////////////////////////////////////////////////////////
// IPU result checker
// Tracks accepted operations and credits, compares results in order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ipu_params.svh"

module ipu_checker import ipu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         op_valid_i,
    input  logic         op_ready_i,
    input  ipu_tag_t     op_tag_i,
    input  elen_t        exp_i,
    input  logic [191:0] name_i,
    input  logic         result_credit_i,
    input  logic         result_valid_i,
    input  elen_t        result_i,
    input  ipu_tag_t     tag_i,
    output int           errors_o,
    output int           results_o
);

    logic [191:0] name_q[$];
    ipu_tag_t     tag_q[$];
    elen_t        exp_q[$];
    int           acc_q[$];
    int           cyc;
    int           credits;
    int           in_flight;

    // Credit model and acceptance record
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (rst_i) begin
            credits   <= `IPU_CREDITS;
            in_flight <= 0;
        end else begin
            credits   <= credits - int'(op_valid_i && op_ready_i) + int'(result_credit_i);
            in_flight <= in_flight + int'(op_valid_i && op_ready_i) - int'(result_credit_i);
            if (op_valid_i && op_ready_i) begin
                name_q.push_back(name_i);
                tag_q.push_back(op_tag_i);
                exp_q.push_back(exp_i);
                acc_q.push_back(cyc);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Comparison on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        logic [191:0] name;
        ipu_tag_t     tag;
        elen_t        exp;
        int           acc;
        int           n_err;
        n_err = 0;
        if (!rst_i) begin
            if (op_ready_i !== (credits > 0)) begin
                $display("CHECK FAILED credit_ready expected %b actual %b",
                         credits > 0, op_ready_i);
                n_err++;
            end
            if (in_flight > `IPU_CREDITS) begin
                $display("More operations in flight (%0d) than credits granted", in_flight);
                n_err++;
            end
            if (result_valid_i === 1'b1) begin
                results_o <= results_o + 1;
                if (acc_q.size() == 0) begin
                    $display("A result arrived while no operation was outstanding");
                    n_err++;
                end else begin
                    name = name_q.pop_front();
                    tag  = tag_q.pop_front();
                    exp  = exp_q.pop_front();
                    acc  = acc_q.pop_front();
                    if (cyc - acc != 2) begin
                        $display("Result of %0s came %0d cycles after acceptance, not 2",
                                 name, cyc - acc);
                        n_err++;
                    end
                    if (tag_i !== tag) begin
                        $display("CHECK FAILED %0s tag expected %h actual %h", name, tag, tag_i);
                        n_err++;
                    end
                    if (result_i !== exp) begin
                        $display("CHECK FAILED %0s expected %h actual %h", name, exp, result_i);
                        n_err++;
                    end
                end
            end else if (acc_q.size() != 0 && cyc - acc_q[0] > 2) begin
                name = name_q.pop_front();
                void'(tag_q.pop_front());
                void'(exp_q.pop_front());
                void'(acc_q.pop_front());
                $display("No result came for %0s two cycles after acceptance", name);
                n_err++;
            end
        end
        errors_o <= errors_o + n_err;
    end

    initial begin
        cyc       = 0;
        credits   = `IPU_CREDITS;
        in_flight = 0;
        errors_o  = 0;
        results_o = 0;
    end

endmodule

// File: rtl/spatz_ipu.sv
////////////////////////////////////////////////////////////////////////////
// Integer processing unit
// Decode, four SIMD lanes and result collection, credit flow control
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ipu_params.svh"

module spatz_ipu import ipu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     op_valid_i,
    input  op_e      op_i,
    input  sew_e     sew_i,
    input  elen_t    op_s1_i,
    input  elen_t    op_s2_i,
    input  ipu_tag_t tag_i,
    input  logic     result_credit_i,
    output logic     op_ready_o,
    output logic     result_valid_o,
    output elen_t    result_o,
    output ipu_tag_t tag_o
);

    logic [`IPU_NUM_LANES-1:0] lane_valid;
    logic [`IPU_NUM_LANES-1:0] res_valid;
    lane_cmd_e                 lane_cmd;
    logic                      lane_signed;
    lane8_t                    a8_0, b8_0, a8_1, b8_1;
    lane16_t                   a16, b16;
    lane32_t                   a32, b32;
    lane8_t                    r8_0, r8_1;
    lane16_t                   r16;
    lane32_t                   r32;
    sew_e                      dec_sew;
    ipu_tag_t                  dec_tag;
    logic                      dec_valid;

    ipu_operand_decode i_decode (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .op_s1_i        (op_s1_i),
        .op_s2_i        (op_s2_i),
        .tag_i          (tag_i),
        .result_credit_i(result_credit_i),
        .op_ready_o     (op_ready_o),
        .lane_valid_o   (lane_valid),
        .lane_cmd_o     (lane_cmd),
        .lane_signed_o  (lane_signed),
        .a8_0_o         (a8_0),
        .b8_0_o         (b8_0),
        .a8_1_o         (a8_1),
        .b8_1_o         (b8_1),
        .a16_o          (a16),
        .b16_o          (b16),
        .a32_o          (a32),
        .b32_o          (b32),
        .sew_o          (dec_sew),
        .tag_o          (dec_tag),
        .valid_o        (dec_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // SIMD lanes
    ////////////////////////////////////////////////////////////////////////////

    ipu_simd_lane #(.lane_t(lane8_t)) i_lane_8b_0 (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (lane_valid[0]),
        .cmd_i   (lane_cmd),
        .signed_i(lane_signed),
        .a_i     (a8_0),
        .b_i     (b8_0),
        .valid_o (res_valid[0]),
        .result_o(r8_0)
    );

    ipu_simd_lane #(.lane_t(lane8_t)) i_lane_8b_1 (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (lane_valid[1]),
        .cmd_i   (lane_cmd),
        .signed_i(lane_signed),
        .a_i     (a8_1),
        .b_i     (b8_1),
        .valid_o (res_valid[1]),
        .result_o(r8_1)
    );

    ipu_simd_lane #(.lane_t(lane16_t)) i_lane_16b (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (lane_valid[2]),
        .cmd_i   (lane_cmd),
        .signed_i(lane_signed),
        .a_i     (a16),
        .b_i     (b16),
        .valid_o (res_valid[2]),
        .result_o(r16)
    );

    ipu_simd_lane #(.lane_t(lane32_t)) i_lane_32b (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (lane_valid[3]),
        .cmd_i   (lane_cmd),
        .signed_i(lane_signed),
        .a_i     (a32),
        .b_i     (b32),
        .valid_o (res_valid[3]),
        .result_o(r32)
    );

    ipu_result_collect i_collect (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_i       (dec_valid),
        .sew_i         (dec_sew),
        .tag_i         (dec_tag),
        .r8_0_i        (r8_0),
        .r8_1_i        (r8_1),
        .r16_i         (r16),
        .r32_i         (r32),
        .lane_valid_i  (res_valid),
        .result_valid_o(result_valid_o),
        .result_o      (result_o),
        .tag_o         (tag_o)
    );

endmodule

// File: rtl/ipu_result_collect.sv
////////////////////////////////////////////////////////////////////////////
// IPU result collector
// Holds element width and tag alongside the lanes, packs lane results
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ipu_params.svh"

module ipu_result_collect import ipu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  sew_e                      sew_i,
    input  ipu_tag_t                  tag_i,
    input  lane8_t                    r8_0_i,
    input  lane8_t                    r8_1_i,
    input  lane16_t                   r16_i,
    input  lane32_t                   r32_i,
    input  logic [`IPU_NUM_LANES-1:0] lane_valid_i,
    output logic                      result_valid_o,
    output elen_t                     result_o,
    output ipu_tag_t                  tag_o
);

    sew_e    sew_q;
    lane8_t  m8_0, m8_1;
    lane16_t m16;
    lane32_t m32;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            sew_q <= sew_i;
            tag_o <= tag_i;
        end
    end

    // Idle lanes hold stale data
    assign m8_0 = lane_valid_i[0] ? r8_0_i : '0;
    assign m8_1 = lane_valid_i[1] ? r8_1_i : '0;
    assign m16  = lane_valid_i[2] ? r16_i  : '0;
    assign m32  = lane_valid_i[3] ? r32_i  : '0;

    always_comb begin
        case (sew_q)
            EW_8:    result_o = {m32[7:0], m16[7:0], m8_1, m8_0};
            EW_16:   result_o = {m32[15:0], m16};
            default: result_o = m32;
        endcase
    end

endmodule

// File: rtl/ipu_simd_lane.sv
////////////////////////////////////////////////////////////////////////////
// IPU SIMD lane
// One registered integer ALU lane at the width of its payload type
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_simd_lane import ipu_pkg::*; #(
    parameter type lane_t = lane32_t
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      valid_i,
    input  lane_cmd_e cmd_i,
    input  logic      signed_i,
    input  lane_t     a_i,
    input  lane_t     b_i,
    output logic      valid_o,
    output lane_t     result_o
);

    localparam int unsigned W = $bits(lane_t);

    lane_t a_cmp, b_cmp;
    logic  a_lt_b;
    lane_t res_d;

    // Flipping the sign bit turns a signed compare into an unsigned one
    assign a_cmp  = {a_i[W-1] ^ signed_i, a_i[W-2:0]};
    assign b_cmp  = {b_i[W-1] ^ signed_i, b_i[W-2:0]};
    assign a_lt_b = (a_cmp < b_cmp);

    always_comb begin
        case (cmd_i)
            LANE_SUB: res_d = a_i - b_i;
            LANE_AND: res_d = a_i & b_i;
            LANE_OR:  res_d = a_i | b_i;
            LANE_XOR: res_d = a_i ^ b_i;
            LANE_MIN: res_d = a_lt_b ? a_i : b_i;
            LANE_MAX: res_d = a_lt_b ? b_i : a_i;
            default:  res_d = a_i + b_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Result only moves when the lane is in use
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o <= res_d;
        end
    end

endmodule

// File: rtl/ipu_operand_decode.sv
////////////////////////////////////////////////////////////////////////////
// IPU operand decode
// Credit counter, opcode translation and operand distribution into
// registered SIMD lane inputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ipu_params.svh"

module ipu_operand_decode import ipu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      op_valid_i,
    input  op_e                       op_i,
    input  sew_e                      sew_i,
    input  elen_t                     op_s1_i,
    input  elen_t                     op_s2_i,
    input  ipu_tag_t                  tag_i,
    input  logic                      result_credit_i,
    output logic                      op_ready_o,
    output logic [`IPU_NUM_LANES-1:0] lane_valid_o,
    output lane_cmd_e                 lane_cmd_o,
    output logic                      lane_signed_o,
    output lane8_t                    a8_0_o,
    output lane8_t                    b8_0_o,
    output lane8_t                    a8_1_o,
    output lane8_t                    b8_1_o,
    output lane16_t                   a16_o,
    output lane16_t                   b16_o,
    output lane32_t                   a32_o,
    output lane32_t                   b32_o,
    output sew_e                      sew_o,
    output ipu_tag_t                  tag_o,
    output logic                      valid_o
);

    localparam int unsigned CRED_W = $clog2(`IPU_CREDITS + 1);

    logic [CRED_W-1:0]         credits_q;
    logic                      accept;
    lane_cmd_e                 cmd;
    logic                      is_signed;
    lane16_t                   a16_d, b16_d;
    lane32_t                   a32_d, b32_d;
    logic [`IPU_NUM_LANES-1:0] lane_valid_d;

    ////////////////////////////////////////////////////////////////////////////
    // Credits
    ////////////////////////////////////////////////////////////////////////////

    assign op_ready_o = (credits_q != '0);
    assign accept     = op_valid_i && op_ready_o;

    // Spend and return in the same cycle cancel
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits_q <= CRED_W'(`IPU_CREDITS);
        end else if (accept && !result_credit_i) begin
            credits_q <= credits_q - 1'b1;
        end else if (!accept && result_credit_i) begin
            credits_q <= credits_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Opcode and distribution
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        is_signed = 1'b0;
        case (op_i)
            VSUB:    cmd = LANE_SUB;
            VAND:    cmd = LANE_AND;
            VOR:     cmd = LANE_OR;
            VXOR:    cmd = LANE_XOR;
            VMINU:   cmd = LANE_MIN;
            VMAXU:   cmd = LANE_MAX;
            VMIN: begin
                cmd       = LANE_MIN;
                is_signed = 1'b1;
            end
            VMAX: begin
                cmd       = LANE_MAX;
                is_signed = 1'b1;
            end
            default: cmd = LANE_ADD;
        endcase
    end

    // Upper elements widen into the bigger lanes
    always_comb begin
        case (sew_i)
            EW_8: begin
                a16_d        = {{8{is_signed & op_s1_i[23]}}, op_s1_i[23:16]};
                b16_d        = {{8{is_signed & op_s2_i[23]}}, op_s2_i[23:16]};
                a32_d        = {{24{is_signed & op_s1_i[31]}}, op_s1_i[31:24]};
                b32_d        = {{24{is_signed & op_s2_i[31]}}, op_s2_i[31:24]};
                lane_valid_d = 4'b1111;
            end
            EW_16: begin
                a16_d        = op_s1_i[15:0];
                b16_d        = op_s2_i[15:0];
                a32_d        = {{16{is_signed & op_s1_i[31]}}, op_s1_i[31:16]};
                b32_d        = {{16{is_signed & op_s2_i[31]}}, op_s2_i[31:16]};
                lane_valid_d = 4'b1100;
            end
            default: begin
                a16_d        = op_s1_i[15:0];
                b16_d        = op_s2_i[15:0];
                a32_d        = op_s1_i;
                b32_d        = op_s2_i;
                lane_valid_d = 4'b1000;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o      <= 1'b0;
            lane_valid_o <= '0;
        end else begin
            valid_o      <= accept;
            lane_valid_o <= accept ? lane_valid_d : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            lane_cmd_o    <= cmd;
            lane_signed_o <= is_signed;
            a8_0_o        <= op_s1_i[7:0];
            b8_0_o        <= op_s2_i[7:0];
            a8_1_o        <= op_s1_i[15:8];
            b8_1_o        <= op_s2_i[15:8];
            a16_o         <= a16_d;
            b16_o         <= b16_d;
            a32_o         <= a32_d;
            b32_o         <= b32_d;
            sew_o         <= sew_i;
            tag_o         <= tag_i;
        end
    end

endmodule

// File: rtl/ipu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// IPU package
// Opcodes, element widths, lane commands and payload types
////////////////////////////////////////////////////////////////////////////

`include "ipu_params.svh"

package ipu_pkg;

    typedef logic [`IPU_ELEN-1:0]  elen_t;
    typedef logic [`IPU_TAG_W-1:0] ipu_tag_t;

    // Lane payloads
    typedef logic [7:0]  lane8_t;
    typedef logic [15:0] lane16_t;
    typedef logic [31:0] lane32_t;

    typedef enum logic [3:0] {
        VADD, VSUB, VAND, VOR, VXOR, VMIN, VMAX, VMINU, VMAXU
    } op_e;

    typedef enum logic [1:0] {
        EW_8  = 2'd0,
        EW_16 = 2'd1,
        EW_32 = 2'd2
    } sew_e;

    // Signedness of min/max travels separately
    typedef enum logic [2:0] {
        LANE_ADD, LANE_SUB, LANE_AND, LANE_OR, LANE_XOR, LANE_MIN, LANE_MAX
    } lane_cmd_e;

endpackage

// File: rtl/ipu_params.svh
////////////////////////////////////////////////////////////////////////////
// IPU parameters
// Datapath and tag widths, consumer credits and SIMD lane count
////////////////////////////////////////////////////////////////////////////

`ifndef IPU_PARAMS_SVH
`define IPU_PARAMS_SVH

// Element datapath width
`define IPU_ELEN 32

// Transaction tag width
`define IPU_TAG_W 4

// Result credits granted after reset, at least 1
`define IPU_CREDITS 4

// Lanes 8_0, 8_1, 16 and 32
`define IPU_NUM_LANES 4

`endif
